// File: Makefile
# Verilator build and run for the reduced Blimp core

VERILATOR ?= verilator
TOP       ?= blimp_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

SOURCES := $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; \
	else echo "FAIL: simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+verilog
verilog/blimp_inst_pkg.sv
verilog/blimp_notif_pkg.sv
verilog/issue_unit.sv
verilog/alu_unit.sv
verilog/pipelined_multiplier.sv
verilog/writeback_commit_unit.sv
verilog/blimp_core.sv
sim/blimp_clkgen.sv
sim/blimp_chk.sv
sim/blimp_tb.sv

// File: sim/blimp_chk.sv
/*
 * Protocol assertions on the core, attached to blimp_core by the bind
 * at the bottom. Covers dispatch exclusivity, quiet outputs in reset
 * and sanity of the commit trace.
 */

`timescale 1ns/1ps

module blimp_chk (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     alu_val,
  input  logic                     mul_val,
  input  logic                     inst_rdy,
  input  logic                     trace_val,
  input  blimp_notif_pkg::trace_t  trace
);

  logic [31:0] last_pc_q;    // pc of the previous commit
  logic        have_last_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      have_last_q <= 1'b0;
    end else if (trace_val) begin
      have_last_q <= 1'b1;
      last_pc_q   <= trace.pc;
    end
  end

  //----------------------------------------------------------------------
  // Properties
  //----------------------------------------------------------------------

  one_pipe_a: assert property (@(posedge clk) disable iff (reset)
    !(alu_val && mul_val))
    else $error("ALU and multiplier dispatched in the same cycle");

  // Second reset cycle onward, state is known by then
  quiet_reset_a: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!trace_val && !inst_rdy))
    else $error("trace_val or inst_rdy high while reset is asserted");

  no_x0_write_a: assert property (@(posedge clk) disable iff (reset)
    (trace_val && trace.wen) |-> (trace.waddr != '0))
    else $error("trace reports a register write to x0");

  unique_pc_a: assert property (@(posedge clk) disable iff (reset)
    (trace_val && have_last_q) |-> (trace.pc != last_pc_q))
    else $error("two consecutive commits carry the same pc");

endmodule

bind blimp_core blimp_chk CHK (
  .clk       (clk),
  .reset     (reset),
  .alu_val   (alu_val),
  .mul_val   (mul_val),
  .inst_rdy  (inst_rdy),
  .trace_val (trace_val),
  .trace     (trace)
);

// File: sim/blimp_clkgen.sv
/*
 * Clock and reset source for the core testbench.
 * Reset is held for a fixed number of rising edges, then dropped
 * just after an edge like every other testbench input.
 */

`timescale 1ns/1ps

module blimp_clkgen #(
  parameter int p_period       = 20,  // ns
  parameter int p_reset_cycles = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(p_period / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (p_reset_cycles) @(posedge clk);
    #1 reset = 1'b0;  // Released off the edge
  end

endmodule

// File: sim/blimp_tb.sv
/*
 * Testbench for the reduced Blimp core. Sends LFSR generated add, addi
 * and mul instructions with random gaps, runs each accepted one on an
 * in-order register model and checks every commit against it.
 */

`timescale 1ns/1ps
`include "blimp_config.svh"

module blimp_tb;

  localparam int          c_num_inst = 400;
  localparam int          c_num_init = 7;   // Leading addi's that load x1..x7
  localparam int          c_timeout  = c_num_inst * (`BLIMP_MUL_STAGES + 6) + 50;
  // Full ROB emptying once nothing new is issued
  localparam int          c_drain    = (1 << `BLIMP_SEQ_NUM_BITS) + `BLIMP_MUL_STAGES + 10;
  localparam logic [31:0] c_seed     = 32'h50fd59a6;

  logic                     clk;
  logic                     reset;
  logic                     inst_val;
  logic                     inst_rdy;
  logic                     trace_val;
  blimp_inst_pkg::inst_t    inst;
  blimp_notif_pkg::trace_t  trace;

  logic [31:0]              lfsr_q;
  logic [31:0]              model_rf [8];   // Only x0..x7 are used
  logic [31:0]              next_pc;
  blimp_notif_pkg::trace_t  exp_q [$];      // Expected commits in program order
  int                       sent   = 0;
  int                       cycles = 0;

  blimp_clkgen #(.p_period(20), .p_reset_cycles(8)) CLKGEN (.clk(clk), .reset(reset));

  blimp_core DUT (
    .clk       (clk),
    .reset     (reset),
    .inst_val  (inst_val),
    .inst      (inst),
    .inst_rdy  (inst_rdy),
    .trace_val (trace_val),
    .trace     (trace)
  );

  //----------------------------------------------------------------------
  // Random source and failure exit
  //----------------------------------------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'hA300_0000;  // Taps 32 30 26 25
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v      = {v[30:0], lfsr_q[0]};  // One step per bit
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic stop_with_failure(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  //----------------------------------------------------------------------
  // Stimulus and reference model
  //----------------------------------------------------------------------

  task automatic build_inst(input int idx, input logic [31:0] pc,
                            output blimp_inst_pkg::inst_t i);
    logic [31:0] bits;
    i    = '0;
    i.pc = pc;
    if (idx < c_num_init) begin      // Give x1..x7 known values first
      i.op = blimp_inst_pkg::op_addi;
      i.rd = 5'(idx + 1);
      draw_bits(32, bits);
      i.imm = bits;
    end else begin
      draw_bits(2, bits);
      case (bits[1:0])
        2'd0:    i.op = blimp_inst_pkg::op_add;
        2'd1:    i.op = blimp_inst_pkg::op_addi;
        default: i.op = blimp_inst_pkg::op_mul;  // Half the mix gives long mul runs
      endcase
      draw_bits(3, bits);
      i.rd = {2'b00, bits[2:0]};     // Small range for frequent hazards
      draw_bits(3, bits);
      i.rs1 = {2'b00, bits[2:0]};
      draw_bits(3, bits);
      i.rs2 = {2'b00, bits[2:0]};
      if (i.op == blimp_inst_pkg::op_addi) begin
        draw_bits(32, bits);
        i.imm = bits;
      end
    end
  endtask

  function automatic logic [31:0] read_model_reg(input logic [4:0] a);
    if (a == 5'd0) return 32'd0;
    return model_rf[a[2:0]];
  endfunction

  task automatic execute_model(input blimp_inst_pkg::inst_t i);
    logic [31:0]             a;
    logic [31:0]             b;
    logic [31:0]             r;
    logic [63:0]             prod;
    blimp_notif_pkg::trace_t t;
    a = read_model_reg(i.rs1);
    b = read_model_reg(i.rs2);
    case (i.op)
      blimp_inst_pkg::op_add:  r = a + b;      // Wraps at 32 bits
      blimp_inst_pkg::op_addi: r = a + i.imm;
      default: begin
        prod = {32'd0, a} * {32'd0, b};
        r    = prod[31:0];                      // Low half only
      end
    endcase
    t.pc    = i.pc;
    t.waddr = i.rd;
    t.wdata = r;
    t.wen   = (i.rd != 5'd0);
    exp_q.push_back(t);
    if (i.rd != 5'd0) model_rf[i.rd[2:0]] = r;
  endtask

  //----------------------------------------------------------------------
  // Trace compare
  //----------------------------------------------------------------------

  task automatic check_trace(input blimp_notif_pkg::trace_t got);
    blimp_notif_pkg::trace_t exp;
    if (exp_q.size() == 0) begin
      stop_with_failure($sformatf("commit of pc %h at %0t with nothing left to expect",
                                  got.pc, $time));
    end else begin
      exp = exp_q.pop_front();
      if (got.pc != exp.pc)
        $display("error at %0t: pc got %h expected %h", $time, got.pc, exp.pc);
      if (got.waddr != exp.waddr)
        $display("error at %0t: pc %h waddr got %0d expected %0d",
                 $time, exp.pc, got.waddr, exp.waddr);
      if (got.wdata != exp.wdata)
        $display("error at %0t: pc %h wdata got %h expected %h",
                 $time, exp.pc, got.wdata, exp.wdata);
      if (got.wen != exp.wen)
        $display("error at %0t: pc %h wen got %b expected %b",
                 $time, exp.pc, got.wen, exp.wen);
      if (got !== exp) stop_with_failure("trace record differs from the model");
    end
  endtask

  always @(negedge clk) begin  // Stable half way between edges
    if (!reset && trace_val) check_trace(trace);
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > c_timeout)
      stop_with_failure($sformatf("timeout after %0d cycles, %0d sent, %0d not committed",
                                  cycles, sent, exp_q.size()));
  end

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------

  initial begin
    logic [31:0] bits;
    logic        took;
    lfsr_q   = c_seed;
    inst_val = 1'b0;
    inst     = '0;
    next_pc  = 32'd0;
    for (int r = 0; r < 8; r++) model_rf[r] = 32'd0;

    @(posedge clk);
    while (reset) @(posedge clk);
    #1;
    while (sent < c_num_inst) begin
      if (!inst_val) begin            // Held ones stay put until taken
        draw_bits(2, bits);
        if (bits[1:0] != 2'b00) begin // About 75 percent valid
          build_inst(sent, next_pc, inst);
          inst_val = 1'b1;
        end
      end
      @(negedge clk);
      took = inst_val && inst_rdy;    // Handshake as seen by the next edge
      @(posedge clk);
      #1;
      if (took) begin
        execute_model(inst);
        sent     = sent + 1;
        next_pc  = next_pc + 32'd4;
        inst_val = 1'b0;
      end
    end
    inst_val = 1'b0;

    for (int w = 0; w < c_drain && exp_q.size() != 0; w++) begin
      @(posedge clk);
    end
    repeat (2 * `BLIMP_MUL_STAGES + 10) @(posedge clk);  // Catch stray commits
    if (exp_q.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      stop_with_failure("instructions left without a commit at the end");
    end
  end

endmodule

// File: verilog/alu_unit.sv
/*
 * Single-cycle ALU pipe. Adds the two dispatched operands, which covers
 * both add and add-immediate since issue already chose operand b.
 */

`timescale 1ns/1ps

module alu_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_val,
  input  blimp_inst_pkg::dispatch_t  req,
  output logic                       res_val,
  output blimp_notif_pkg::result_t   res
);

  blimp_notif_pkg::result_t res_d;

  // Tag fields pass straight through
  always_comb begin
    res_d.seq   = req.seq;
    res_d.pc    = req.pc;
    res_d.rd    = req.rd;
    res_d.wdata = req.operand_a + req.operand_b;  // Wraps at 32 bits
  end

  //----------------------------------------------------------------------
  // Output register
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      res_val <= 1'b0;
    end else begin
      res_val <= in_val;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val) res <= res_d;  // Only load on a real op
  end

endmodule

// File: verilog/blimp_config.svh
/*
 * Sizing macros for the reduced Blimp core.
 * Included by the packages and by any RTL file that needs a width or depth.
 */

`ifndef BLIMP_CONFIG_SVH
`define BLIMP_CONFIG_SVH

// Sequence number width, sets ROB depth and max in flight
`define BLIMP_SEQ_NUM_BITS 5

// Architectural registers, x0 reads as zero
`define BLIMP_NUM_REGS 32

`define BLIMP_DATA_BITS 32  // Datapath width

// Multiplier latency in cycles
`define BLIMP_MUL_STAGES 4

`endif

// File: verilog/blimp_core.sv
/*
 * Reduced Blimp core top level. Issue feeds an ALU and a pipelined
 * multiplier side by side; the commit unit writes back and retires.
 */

`timescale 1ns/1ps
`include "blimp_config.svh"

module blimp_core (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_val,
  input  blimp_inst_pkg::inst_t     inst,
  output logic                      inst_rdy,
  output logic                      trace_val,
  output blimp_notif_pkg::trace_t   trace
);

  //----------------------------------------------------------------------
  // Internal traffic
  //----------------------------------------------------------------------

  logic                        alu_val, mul_val;      // Dispatch strobes
  blimp_inst_pkg::dispatch_t   alu_req, mul_req;
  logic                        alu_res_val, mul_res_val;
  blimp_notif_pkg::result_t    alu_res, mul_res;
  logic                        cmp0_val, cmp1_val;    // Completions
  blimp_notif_pkg::result_t    cmp0, cmp1;
  logic                        commit_val;

  //----------------------------------------------------------------------
  // Units
  //----------------------------------------------------------------------

  issue_unit DIU (.*);

  alu_unit ALU_XU (
    .clk     (clk),
    .reset   (reset),
    .in_val  (alu_val),
    .req     (alu_req),
    .res_val (alu_res_val),
    .res     (alu_res)
  );

  pipelined_multiplier #(
    .p_stages (`BLIMP_MUL_STAGES)
  ) MUL_XU (
    .clk     (clk),
    .reset   (reset),
    .in_val  (mul_val),
    .req     (mul_req),
    .res_val (mul_res_val),
    .res     (mul_res)
  );

  writeback_commit_unit WCU (.*);

endmodule

// File: verilog/blimp_inst_pkg.sv
/*
 * Instruction side types: opcode encoding, the pre-decoded instruction
 * taken from the input stream and the dispatch record sent to the pipes.
 */

`include "blimp_config.svh"

package blimp_inst_pkg;

  // Operation selector, steers to ALU or multiplier
  typedef enum logic [1:0] {
    op_add  = 2'd0,  // rd = rs1 + rs2
    op_addi = 2'd1,  // rd = rs1 + imm
    op_mul  = 2'd2   // rd = low half of rs1 * rs2
  } opcode_e;

  // Pre-decoded instruction from the testbench
  typedef struct packed {
    logic [31:0]                          pc;
    opcode_e                              op;
    logic [$clog2(`BLIMP_NUM_REGS)-1:0]   rd;
    logic [$clog2(`BLIMP_NUM_REGS)-1:0]   rs1;
    logic [$clog2(`BLIMP_NUM_REGS)-1:0]   rs2;
    logic [`BLIMP_DATA_BITS-1:0]          imm;
  } inst_t;

  // Issued instruction with operands already read
  typedef struct packed {
    logic [`BLIMP_SEQ_NUM_BITS-1:0]       seq;
    logic [31:0]                          pc;
    opcode_e                              op;
    logic [$clog2(`BLIMP_NUM_REGS)-1:0]   rd;
    logic [`BLIMP_DATA_BITS-1:0]          operand_a;
    logic [`BLIMP_DATA_BITS-1:0]          operand_b;  // rs2 value or imm
  } dispatch_t;

endpackage

// File: verilog/blimp_notif_pkg.sv
/*
 * Result side types: execute pipe results, reused as completion
 * notifications, and the committed instruction trace record.
 */

`include "blimp_config.svh"

package blimp_notif_pkg;

  // Execute pipe output, also the completion write port format
  typedef struct packed {
    logic [`BLIMP_SEQ_NUM_BITS-1:0]       seq;    // ROB slot
    logic [31:0]                          pc;
    logic [$clog2(`BLIMP_NUM_REGS)-1:0]   rd;
    logic [`BLIMP_DATA_BITS-1:0]          wdata;
  } result_t;

  // One retired instruction on the trace port
  typedef struct packed {
    logic [31:0]                          pc;
    logic [$clog2(`BLIMP_NUM_REGS)-1:0]   waddr;
    logic [`BLIMP_DATA_BITS-1:0]          wdata;
    logic                                 wen;    // Low for x0 writes
  } trace_t;

endpackage

// File: verilog/issue_unit.sv
/*
 * Issue stage. Holds the register file and scoreboard, numbers each
 * accepted instruction and registers it toward the ALU or multiplier.
 * Completions write the register file and are forwarded to reads.
 */

`timescale 1ns/1ps
`include "blimp_config.svh"

module issue_unit (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        inst_val,
  input  blimp_inst_pkg::inst_t       inst,
  output logic                        inst_rdy,
  output logic                        alu_val,
  output logic                        mul_val,
  output blimp_inst_pkg::dispatch_t   alu_req,
  output blimp_inst_pkg::dispatch_t   mul_req,
  input  logic                        cmp0_val,
  input  logic                        cmp1_val,
  input  blimp_notif_pkg::result_t    cmp0,
  input  blimp_notif_pkg::result_t    cmp1,
  input  logic                        commit_val
);

  localparam int c_addr_bits = $clog2(`BLIMP_NUM_REGS);
  localparam int c_max_in_flight = 1 << `BLIMP_SEQ_NUM_BITS;

  logic [`BLIMP_DATA_BITS-1:0]     rf_q [`BLIMP_NUM_REGS];
  logic [`BLIMP_NUM_REGS-1:0]      pend_q;      // Scoreboard
  logic [`BLIMP_NUM_REGS-1:0]      cmp_mask;    // Regs completing now
  logic [`BLIMP_NUM_REGS-1:0]      pend_eff;
  logic [`BLIMP_SEQ_NUM_BITS-1:0]  seq_q;
  logic [`BLIMP_SEQ_NUM_BITS:0]    in_flight_q; // One extra bit for full
  logic                            uses_rs2;
  logic                            hazard;
  logic                            full;
  logic                            accept;
  blimp_inst_pkg::dispatch_t       disp_d;
  blimp_inst_pkg::dispatch_t       disp_q;

  //----------------------------------------------------------------------
  // Register read with completion forwarding
  //----------------------------------------------------------------------

  function automatic logic [`BLIMP_DATA_BITS-1:0] read_reg(
    input logic [c_addr_bits-1:0] addr
  );
    logic [`BLIMP_DATA_BITS-1:0] val;
    val = rf_q[addr];
    if (cmp0_val && cmp0.rd == addr) val = cmp0.wdata;  // ALU bypass
    if (cmp1_val && cmp1.rd == addr) val = cmp1.wdata;  // Mul bypass
    if (addr == '0) val = '0;                           // x0 hard-wired
    return val;
  endfunction

  //----------------------------------------------------------------------
  // Hazard check and handshake
  //----------------------------------------------------------------------

  always_comb begin
    cmp_mask = '0;
    if (cmp0_val) cmp_mask[cmp0.rd] = 1'b1;
    if (cmp1_val) cmp_mask[cmp1.rd] = 1'b1;
  end

  assign pend_eff = pend_q & ~cmp_mask;  // Completing regs count as ready
  assign uses_rs2 = (inst.op != blimp_inst_pkg::op_addi);
  assign hazard   = pend_eff[inst.rs1] | (uses_rs2 & pend_eff[inst.rs2])
                  | pend_eff[inst.rd];                   // RAW and WAW
  assign full     = (in_flight_q == c_max_in_flight[`BLIMP_SEQ_NUM_BITS:0]);
  assign inst_rdy = !reset && !hazard && !full;
  assign accept   = inst_val && inst_rdy;

  always_comb begin
    disp_d.seq       = seq_q;
    disp_d.pc        = inst.pc;
    disp_d.op        = inst.op;
    disp_d.rd        = inst.rd;
    disp_d.operand_a = read_reg(inst.rs1);
    disp_d.operand_b = uses_rs2 ? read_reg(inst.rs2) : inst.imm;
  end

  //----------------------------------------------------------------------
  // State
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin  // Both write ports, x0 never written
    if (cmp0_val && cmp0.rd != '0) rf_q[cmp0.rd] <= cmp0.wdata;
    if (cmp1_val && cmp1.rd != '0) rf_q[cmp1.rd] <= cmp1.wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q      <= '0;
      seq_q       <= '0;
      in_flight_q <= '0;
      alu_val     <= 1'b0;
      mul_val     <= 1'b0;
    end else begin
      pend_q <= pend_eff;  // Clear on completion first
      if (accept && inst.rd != '0) pend_q[inst.rd] <= 1'b1;
      if (accept) seq_q <= seq_q + 1'b1;
      case ({accept, commit_val})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: in_flight_q <= in_flight_q;  // Both or neither
      endcase
      alu_val <= accept && (inst.op != blimp_inst_pkg::op_mul);
      mul_val <= accept && (inst.op == blimp_inst_pkg::op_mul);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) disp_q <= disp_d;  // Payload, qualified by the strobes
  end

  assign alu_req = disp_q;
  assign mul_req = disp_q;

endmodule

// File: verilog/pipelined_multiplier.sv
/*
 * Multiply pipe. The product is formed in the first stage and then
 * carried down a chain of p_stages registers with its valid bit and
 * tags, so a new multiply may enter every cycle.
 */

`timescale 1ns/1ps
`include "blimp_config.svh"

module pipelined_multiplier #(
  parameter int p_stages = `BLIMP_MUL_STAGES
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_val,
  input  blimp_inst_pkg::dispatch_t  req,
  output logic                       res_val,
  output blimp_notif_pkg::result_t   res
);

  logic [p_stages-1:0]      val_q;            // Valid chain
  blimp_notif_pkg::result_t stage_q [p_stages];
  blimp_notif_pkg::result_t first_d;

  always_comb begin
    first_d.seq   = req.seq;
    first_d.pc    = req.pc;
    first_d.rd    = req.rd;
    first_d.wdata = req.operand_a * req.operand_b;  // Low half kept
  end

  //----------------------------------------------------------------------
  // Stage registers
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_q <= '0;
    end else begin
      val_q[0] <= in_val;
      for (int i = 1; i < p_stages; i++) begin
        val_q[i] <= val_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    stage_q[0] <= first_d;  // Bubbles carry junk, gated by val_q
    for (int i = 1; i < p_stages; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  assign res_val = val_q[p_stages-1];
  assign res     = stage_q[p_stages-1];

endmodule

// File: verilog/writeback_commit_unit.sv
/*
 * Writeback and commit. Pipe results go straight out as completions to
 * the register file and land in a reorder buffer indexed by sequence
 * number; the head retires in program order onto the trace port.
 */

`timescale 1ns/1ps
`include "blimp_config.svh"

module writeback_commit_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      alu_res_val,
  input  logic                      mul_res_val,
  input  blimp_notif_pkg::result_t  alu_res,
  input  blimp_notif_pkg::result_t  mul_res,
  output logic                      cmp0_val,
  output logic                      cmp1_val,
  output blimp_notif_pkg::result_t  cmp0,
  output blimp_notif_pkg::result_t  cmp1,
  output logic                      commit_val,
  output logic                      trace_val,
  output blimp_notif_pkg::trace_t   trace
);

  localparam int c_depth = 1 << `BLIMP_SEQ_NUM_BITS;

  blimp_notif_pkg::trace_t          rob_q [c_depth];  // Retire records
  logic [c_depth-1:0]               done_q;
  logic [`BLIMP_SEQ_NUM_BITS-1:0]   head_q;           // Oldest in flight

  // Build the trace record at writeback time
  function automatic blimp_notif_pkg::trace_t to_trace(
    input blimp_notif_pkg::result_t r
  );
    blimp_notif_pkg::trace_t t;
    t.pc    = r.pc;
    t.waddr = r.rd;
    t.wdata = r.wdata;
    t.wen   = (r.rd != '0);  // x0 writes are not reported as writes
    return t;
  endfunction

  //----------------------------------------------------------------------
  // Completion ports
  //----------------------------------------------------------------------

  // Same cycle as the pipe output, RF updates at the coming edge
  assign cmp0_val = alu_res_val;
  assign cmp0     = alu_res;
  assign cmp1_val = mul_res_val;
  assign cmp1     = mul_res;

  //----------------------------------------------------------------------
  // Reorder buffer
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (alu_res_val) rob_q[alu_res.seq] <= to_trace(alu_res);
    if (mul_res_val) rob_q[mul_res.seq] <= to_trace(mul_res);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done_q <= '0;
      head_q <= '0;
    end else begin
      if (commit_val) begin
        done_q[head_q] <= 1'b0;  // Free the slot
        head_q         <= head_q + 1'b1;
      end
      // Head is already done, so these never hit the retiring slot
      if (alu_res_val) done_q[alu_res.seq] <= 1'b1;
      if (mul_res_val) done_q[mul_res.seq] <= 1'b1;
    end
  end

  //----------------------------------------------------------------------
  // In-order retire
  //----------------------------------------------------------------------

  assign commit_val = done_q[head_q];  // At most one per cycle
  assign trace_val  = commit_val;
  assign trace      = rob_q[head_q];

endmodule
